// ==== all.f ====
common/halfFloatPkg.sv
common/accumPkg.sv
fpAdder/fpAddAlign.sv
fpAdder/fpAddNormRound.sv
fpAdder/fpAdder.sv
design/accumSequencer.sv
design/accumTop.sv
verification/clockGen.sv
verification/accumTb.sv

// ==== verification/accumTb.sv ====
`default_nettype none

module accumTb import halfFloatPkg::*, accumPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod   = 4;
	localparam int resetCycles = 8;
	localparam int runCount    = 9;    // Runs over all tests
	localparam int runBudget   = 60;   // Cycles allowed per run
	// Read, Issue and the adder wait per word, then Finish
	localparam int runCycles   = elemCount * (2 + addLatency) + 1;

	logic                 ap_clk;
	logic                 ap_rst;
	logic                 start;
	logic                 continueRun;
	logic                 done;
	logic                 idle;
	logic                 ready;
	logic [addrWidth-1:0] memAddr;
	logic                 memEn;
	halfT                 memData = '0;
	halfT                 sum;
	logic                 sumValid;
	halfT                 memWords [elemCount];   // Memory contents for the next run
	logic [31:0]          lfsrState;
	int                   errCount;
	int                   checkCount;

	clockGen #(.periodNs(clkPeriod), .resetCycles(resetCycles)) clocks (.ap_clk, .ap_rst);

	accumTop UUT (
		.ap_clk, .ap_rst, .start, .continueRun, .done, .idle, .ready,
		.memAddr, .memEn, .memData, .sum, .sumValid
	);

	// Single-port memory with data one cycle after memEn
	always @(posedge ap_clk) begin
		if (memEn) begin
			memData <= memWords[memAddr];
		end
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errCount++;
			$display("Fail %s: expected 0x%0h, got 0x%0h", name, expected, actual);
		end
	endtask

	// Binary16 word for an exact value given in quarters
	function automatic halfT encodeQuarters(input int quarters);
		halfT word;
		int   mag;
		int   lead;
		word = '0;
		mag  = (quarters < 0) ? -quarters : quarters;
		if (mag == 0) begin
			return word;   // +0.0
		end
		lead = 0;
		for (int i = 0; i < 31; i++) begin
			if (mag[i]) begin
				lead = i;
			end
		end
		word.sign = (quarters < 0);
		word.exp  = expWidth'(lead - 2 + expBias);   // Quarter unit is 2^-2
		if (lead >= manWidth) begin
			word.man = manWidth'(mag >> (lead - manWidth));
		end else begin
			word.man = manWidth'(mag << (manWidth - lead));   // Hidden one cut off
		end
		return word;
	endfunction

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randomBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);   // One step per bit
			value     = (value << 1) | int'(lfsrState[0]);
		end
	endtask

	// Returns right after the accepting edge
	task automatic pulseStart();
		@(posedge ap_clk);
		start <= 1'b1;
		@(posedge ap_clk);
		start <= 1'b0;
	endtask

	task automatic pulseContinue();
		@(posedge ap_clk);
		continueRun <= 1'b1;
		@(posedge ap_clk);
		continueRun <= 1'b0;
	endtask

	// One run over memWords with cycles counted from the accepting edge
	task automatic runSum(input halfT expected, input string name, input bit freeDone,
			output int cycles);
		int reads;
		cycles = 0;
		reads  = 0;
		pulseStart();
		do begin
			@(posedge ap_clk);
			cycles++;
			if (memEn) begin
				checkValue("memAddr", reads, memAddr);   // Addresses 0 to 7 in order
				reads++;
			end
			if (!sumValid && (done || ready)) begin
				errCount++;
				$display("done or ready rose before sumValid in %s", name);
			end
		end while (!sumValid && cycles < runBudget);
		if (!sumValid) begin
			errCount++;
			$display("No sumValid within %0d cycles of start in %s", runBudget, name);
		end else begin
			checkValue({"sum in ", name}, expected, sum);
			checkValue("done", 1, done);   // Same cycle as sumValid
			checkValue("ready", 1, ready);
			checkValue("memReads", elemCount, reads);
		end
		if (freeDone) begin
			pulseContinue();
		end
	endtask

	task automatic resetStateTest();
		@(posedge ap_clk);
		checkValue("idle", 1, idle);
		checkValue("done", 0, done);
		checkValue("ready", 0, ready);
		checkValue("sumValid", 0, sumValid);
		checkValue("memEn", 0, memEn);
		checkValue("sum", 0, sum);
	endtask

	task automatic integerSumTest();
		int cycles;
		for (int i = 0; i < elemCount; i++) begin
			memWords[i] = encodeQuarters(4 * (i + 1));   // 1 to 8
		end
		runSum(16'h5080, "integerSum", 1'b0, cycles);
		checkValue("runCycles", runCycles, cycles);
		// done held while the strobes drop
		repeat (5) begin
			@(posedge ap_clk);
			checkValue("done", 1, done);
			checkValue("ready", 0, ready);
			checkValue("sumValid", 0, sumValid);
		end
		pulseContinue();
		@(posedge ap_clk);
		checkValue("done", 0, done);
		checkValue("sum", 16'h5080, sum);   // Kept between runs
	endtask

	task automatic mixedSignTest();
		int values [elemCount];
		int total;
		int cycles;
		// 3, -1.5, 10, 0.25 and their negations
		values = '{12, -6, 40, 1, -12, 6, -40, -1};
		for (int i = 0; i < elemCount; i++) begin
			memWords[i] = encodeQuarters(values[i]);
		end
		runSum(16'h0000, "cancel", 1'b1, cycles);
		// 6.5, -2.25, 0.75 and -8 with zeros make -3
		values = '{26, 0, -9, 0, 3, 0, 0, -32};
		total  = 0;
		for (int i = 0; i < elemCount; i++) begin
			memWords[i] = encodeQuarters(values[i]);
			total += values[i];
		end
		runSum(encodeQuarters(total), "mixedSign", 1'b1, cycles);
	endtask

	// Each 2^-11 is half an ulp of 1.0 so the tie goes to the even mantissa
	task automatic tieEvenTest();
		int cycles;
		memWords[0] = 16'h3C00;
		for (int i = 1; i < elemCount; i++) begin
			memWords[i] = 16'h1000;
		end
		runSum(16'h3C00, "tieEven", 1'b1, cycles);
	endtask

	task automatic heldDoneTest();
		int cycles;
		for (int i = 0; i < elemCount; i++) begin
			memWords[i] = encodeQuarters(4 * (elemCount - i));
		end
		runSum(encodeQuarters(4 * 36), "beforeHold", 1'b0, cycles);
		pulseStart();   // Ignored while done is held
		repeat (10) begin
			@(posedge ap_clk);
			checkValue("memEn", 0, memEn);
			checkValue("done", 1, done);
		end
		pulseContinue();
		// -3 to 4 crossing zero mid-run
		for (int i = 0; i < elemCount; i++) begin
			memWords[i] = encodeQuarters(4 * (i - 3));
		end
		runSum(encodeQuarters(4 * 4), "afterHold", 1'b1, cycles);
		checkValue("runCycles", runCycles, cycles);
	endtask

	task automatic randomSumTest();
		int raw;
		int value;
		int total;
		int cycles;
		repeat (3) begin
			total = 0;
			for (int i = 0; i < elemCount; i++) begin
				randomBits(6, raw);
				value = (raw % 33) - 16;   // -16 to 16
				memWords[i] = encodeQuarters(4 * value);
				total += value;
			end
			runSum(encodeQuarters(4 * total), "randomSum", 1'b1, cycles);
		end
	endtask

	initial begin
		start       = 1'b0;
		continueRun = 1'b0;
		lfsrState   = 32'h2308;
		errCount    = 0;
		checkCount  = 0;
		@(posedge ap_clk);
		while (ap_rst) begin
			@(posedge ap_clk);
		end
		resetStateTest();
		integerSumTest();
		mixedSignTest();
		tieEvenTest();
		heldDoneTest();
		randomSumTest();
		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Budget covers every run plus reset
	initial begin
		#(clkPeriod * (runCount * runBudget + resetCycles));
		$display("Timeout: tests did not finish within the cycle budget");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`default_nettype none

module clockGen #(
	parameter int periodNs    = 4,
	parameter int resetCycles = 8
) (
	output logic ap_clk,
	output logic ap_rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		ap_clk = 1'b0;
		forever begin
			#(periodNs / 2.0) ap_clk = ~ap_clk;
		end
	end

	// Synchronous reset, dropped on a rising edge
	initial begin
		ap_rst = 1'b1;
		repeat (resetCycles) @(posedge ap_clk);
		ap_rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== design/accumTop.sv ====
`default_nettype none

module accumTop import halfFloatPkg::*, accumPkg::*; (
	input  logic                 ap_clk,
	input  logic                 ap_rst,
	input  logic                 start,
	input  logic                 continueRun,
	output logic                 done,
	output logic                 idle,
	output logic                 ready,
	output logic [addrWidth-1:0] memAddr,    // Single-port memory, one-cycle read
	output logic                 memEn,
	input  halfT                 memData,
	output halfT                 sum,
	output logic                 sumValid
);

	// Sequencer to adder
	logic opValid;
	halfT opA;
	halfT opB;
	logic resValid;
	halfT res;

	accumSequencer sequencer (
		.ap_clk, .ap_rst, .start, .continueRun, .done, .idle, .ready,
		.memAddr, .memEn, .memData, .opValid, .opA, .opB, .resValid, .res,
		.sum, .sumValid
	);

	fpAdder adder (
		.ap_clk, .ap_rst, .opValid, .opA, .opB, .resValid, .res
	);

endmodule

`default_nettype wire

// ==== design/accumSequencer.sv ====
`default_nettype none

module accumSequencer import halfFloatPkg::*, accumPkg::*; (
	input  logic                 ap_clk,
	input  logic                 ap_rst,
	input  logic                 start,
	input  logic                 continueRun,
	output logic                 done,
	output logic                 idle,
	output logic                 ready,
	output logic [addrWidth-1:0] memAddr,
	output logic                 memEn,
	input  halfT                 memData,
	output logic                 opValid,
	output halfT                 opA,
	output halfT                 opB,
	input  logic                 resValid,
	input  halfT                 res,
	output halfT                 sum,
	output logic                 sumValid
);

	seqStateT             state;
	seqStateT             nextState;
	logic [addrWidth-1:0] elemIdx;     // Current word, also the memory address
	logic [latWidth-1:0]  latCnt;      // Cycles spent in Wait
	logic                 doneHeld;    // done kept until continueRun
	logic                 accept;
	logic                 lastElem;
	logic                 latDone;
	halfT                 accSum;      // Running sum

	assign accept   = (state == Idle) && start && !doneHeld;   // Held done blocks start
	assign lastElem = (elemIdx == addrWidth'(elemCount - 1));
	assign latDone  = (latCnt == latWidth'(addLatency - 1));   // Lines up with resValid

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (accept) begin
					nextState = Read;
				end
			end
			Read:  nextState = Issue;
			Issue: nextState = Wait;
			Wait: begin
				if (latDone) begin
					nextState = lastElem ? Finish : Read;
				end
			end
			Finish:  nextState = Idle;
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state    <= Idle;
			elemIdx  <= '0;
			latCnt   <= '0;
			doneHeld <= 1'b0;
			sum      <= '0;
		end else begin
			state <= nextState;
			if (accept) begin
				elemIdx <= '0;
			end else if (state == Wait && latDone && !lastElem) begin
				elemIdx <= elemIdx + 1'b1;   // Next address
			end
			if (state == Issue) begin
				latCnt <= '0;
			end else if (state == Wait) begin
				latCnt <= latCnt + 1'b1;
			end
			// continueRun has priority, so done may pulse only once
			if (continueRun) begin
				doneHeld <= 1'b0;
			end else if (state == Finish) begin
				doneHeld <= 1'b1;
			end
			if (resValid && lastElem) begin
				sum <= res;   // Final result, kept until the next run ends
			end
		end
	end

	// Each add depends on the previous sum
	always_ff @(posedge ap_clk) begin
		if (accept) begin
			accSum <= '0;   // +0.0
		end else if (resValid) begin
			accSum <= res;
		end
	end

	assign memEn    = (state == Read);
	assign memAddr  = elemIdx;
	assign opValid  = (state == Issue);   // memData arrives this cycle
	assign opA      = accSum;
	assign opB      = memData;
	assign sumValid = (state == Finish);
	assign ready    = (state == Finish);
	assign done     = (state == Finish) || doneHeld;
	assign idle     = (state == Idle) && !start;

endmodule

`default_nettype wire

// ==== fpAdder/fpAdder.sv ====
`default_nettype none

module fpAdder import halfFloatPkg::*; (
	input  logic ap_clk,
	input  logic ap_rst,
	input  logic opValid,
	input  halfT opA,
	input  halfT opB,
	output logic resValid,
	output halfT res
);

	alignedT             alignComb;
	alignedT             alignReg;     // Stage 1
	logic                alignValid;
	logic                effSub;       // Signs differ
	logic [sumWidth-1:0] bigExt;
	logic [sumWidth-1:0] smallExt;
	sumT                 sumComb;
	sumT                 sumReg;       // Stage 2
	logic                addValid;
	halfT                normComb;

	fpAddAlign alignStage (
		.a       (opA),
		.b       (opB),
		.aligned (alignComb)
	);

	// Both mantissas in the raw sum frame, top bit free for the carry
	assign bigExt   = {1'b0, alignReg.bigMan, {grsWidth{1'b0}}};
	assign smallExt = {1'b0, alignReg.smallMan};
	assign effSub   = alignReg.bigSign ^ alignReg.smallSign;

	always_comb begin
		sumComb.sign = alignReg.bigSign;   // Larger magnitude sets the sign
		sumComb.exp  = alignReg.bigExp;
		sumComb.raw  = effSub ? (bigExt - smallExt) : (bigExt + smallExt);
		sumComb.zero = alignReg.zero;
	end

	fpAddNormRound normStage (
		.sumIn (sumReg),
		.res   (normComb)
	);

	// Payload stages
	always_ff @(posedge ap_clk) begin
		alignReg <= alignComb;
		sumReg   <= sumComb;
		res      <= normComb;   // Stage 3
	end

	// Valid travels beside the payload, one pair per cycle
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			alignValid <= 1'b0;
			addValid   <= 1'b0;
			resValid   <= 1'b0;
		end else begin
			alignValid <= opValid;
			addValid   <= alignValid;
			resValid   <= addValid;
		end
	end

endmodule

`default_nettype wire

// ==== fpAdder/fpAddNormRound.sv ====
`default_nettype none

module fpAddNormRound import halfFloatPkg::*; (
	input  sumT  sumIn,
	output halfT res
);

	logic [leadWidth-1:0] lead;        // Leading one position in raw sum
	logic [leadWidth-1:0] shiftAmt;    // Left shift to put it at the MSB
	logic [sumWidth-1:0]  normVal;
	logic [manWidth-1:0]  normMan;
	logic                 guardBit;
	logic                 roundBit;
	logic                 stickyBit;
	logic                 roundUp;
	logic [manWidth:0]    roundMan;    // Top bit catches the rounding carry
	logic [expWidth+1:0]  expAdj;      // Two spare bits so underflow shows as negative
	logic [expWidth-1:0]  expOut;
	logic                 underflow;
	logic                 zeroOut;

	// Priority scan from the LSB, the highest set bit wins
	always_comb begin
		lead = '0;
		for (int i = 0; i < sumWidth; i++) begin
			if (sumIn.raw[i]) begin
				lead = leadWidth'(i);
			end
		end
	end

	// Bit sumWidth-1 is the carry position
	assign shiftAmt = leadWidth'(sumWidth - 1) - lead;
	assign normVal  = sumIn.raw << shiftAmt;

	// Hidden one now at the MSB
	assign normMan   = normVal[sumWidth-2 -: manWidth];
	assign guardBit  = normVal[grsWidth];
	assign roundBit  = normVal[grsWidth-1];
	assign stickyBit = |normVal[grsWidth-2:0];

	// Exponent moves by the distance of the leading one from the hidden-one bit
	// Carry out gives +1, cancellation gives a negative step
	always_comb begin
		expAdj = (expWidth+2)'(sumIn.exp) + (expWidth+2)'(lead);
		expAdj = expAdj - (expWidth+2)'(sumWidth - 2);
	end

	assign underflow = expAdj[expWidth+1] | (expAdj == '0);   // Below 1
	assign zeroOut   = sumIn.zero | (sumIn.raw == '0) | underflow;

	// Nearest even: up when above half, or exactly half with odd LSB
	assign roundUp  = guardBit & (roundBit | stickyBit | normMan[0]);
	assign roundMan = {1'b0, normMan} + (manWidth+1)'(roundUp);

	// Mantissa wrap to zero means one more exponent step
	assign expOut = expAdj[expWidth-1:0] + expWidth'(roundMan[manWidth]);

	always_comb begin
		if (zeroOut) begin
			res = '0;   // Always +0.0
		end else begin
			res.sign = sumIn.sign;
			res.exp  = expOut;
			res.man  = roundMan[manWidth-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== fpAdder/fpAddAlign.sv ====
`default_nettype none

module fpAddAlign import halfFloatPkg::*; (
	input  halfT    a,
	input  halfT    b,
	output alignedT aligned
);

	logic                         aZero;       // Zero exponent, taken as zero
	logic                         bZero;
	logic [expWidth+manWidth-1:0] aMag;        // Magnitude compare key
	logic [expWidth+manWidth-1:0] bMag;
	logic                         aBig;
	halfT                         bigOp;
	halfT                         smallOp;
	logic [manFull-1:0]           bigFull;
	logic [manFull-1:0]           smallFull;
	logic [expWidth-1:0]          expDiff;
	logic [alignWidth-1:0]        preShift;
	logic [alignWidth-1:0]        postShift;
	logic [alignWidth-1:0]        lostMask;
	logic                         sticky;

	// No subnormals, so exponent zero means zero
	assign aZero = (a.exp == '0);
	assign bZero = (b.exp == '0);

	assign aMag = aZero ? '0 : {a.exp, a.man};
	assign bMag = bZero ? '0 : {b.exp, b.man};
	assign aBig = (aMag >= bMag);   // Ties keep a as the larger

	assign bigOp   = aBig ? a : b;
	assign smallOp = aBig ? b : a;

	// Hidden one restored only for nonzero operands
	assign bigFull   = (bigOp.exp == '0) ? '0 : {1'b1, bigOp.man};
	assign smallFull = (smallOp.exp == '0) ? '0 : {1'b1, smallOp.man};

	assign expDiff  = bigOp.exp - smallOp.exp;   // Never negative here
	assign preShift = {smallFull, {grsWidth{1'b0}}};

	// Right shift of the smaller mantissa
	always_comb begin
		postShift = '0;
		lostMask  = '0;
		sticky    = 1'b0;
		if (expDiff >= expWidth'(alignWidth)) begin
			// Everything falls off the end
			sticky = |preShift;
		end else begin
			postShift = preShift >> expDiff;
			lostMask  = (alignWidth'(1) << expDiff) - alignWidth'(1);
			sticky    = |(preShift & lostMask);   // OR of shifted-out bits
		end
	end

	always_comb begin
		aligned.bigSign   = bigOp.sign;
		aligned.bigExp    = bigOp.exp;
		aligned.bigMan    = bigFull;
		// Sticky folds into the lowest kept bit
		aligned.smallMan  = {postShift[alignWidth-1:1], postShift[0] | sticky};
		aligned.smallSign = smallOp.sign;
		aligned.zero      = aZero & bZero;
	end

endmodule

`default_nettype wire

// ==== common/accumPkg.sv ====
`default_nettype none

package accumPkg;

	// Run schedule
	localparam int elemCount  = 8;    // Words per run
	localparam int addrWidth  = 3;    // Covers addresses 0 to elemCount-1
	localparam int addLatency = 3;    // fpAdder depth, opValid to resValid

	// Wait counter sized to the adder depth
	localparam int latWidth = $clog2(addLatency);

	// One element is Read, Issue, then addLatency cycles of Wait
	typedef enum logic [2:0] {
		Idle,
		Read,     // memEn with current address
		Issue,    // memData to adder
		Wait,     // Adder in flight
		Finish    // done, ready and sumValid pulse
	} seqStateT;

endpackage

`default_nettype wire

// ==== common/halfFloatPkg.sv ====
`default_nettype none

package halfFloatPkg;

	// IEEE 754 binary16 field widths
	localparam int expWidth  = 5;
	localparam int manWidth  = 10;
	localparam int halfWidth = 16;   // Sign + exponent + mantissa
	localparam int expBias   = 15;

	// Internal datapath widths
	localparam int manFull    = manWidth + 1;       // Mantissa with hidden one
	localparam int grsWidth   = 3;                  // Guard, round, sticky
	localparam int alignWidth = manFull + grsWidth;
	localparam int sumWidth   = alignWidth + 1;     // One extra bit for carry out
	localparam int leadWidth  = $clog2(sumWidth);   // Leading-one position index

	typedef struct packed {
		logic                sign;
		logic [expWidth-1:0] exp;
		logic [manWidth-1:0] man;
	} halfT;

	// Align stage to add stage
	typedef struct packed {
		logic                  bigSign;     // Sign of larger magnitude operand
		logic [expWidth-1:0]   bigExp;      // Common exponent
		logic [manFull-1:0]    bigMan;
		logic [alignWidth-1:0] smallMan;    // Shifted, GRS in the low bits
		logic                  smallSign;
		logic                  zero;        // Both operands zero
	} alignedT;

	// Add stage to normalize stage
	typedef struct packed {
		logic                sign;
		logic [expWidth-1:0] exp;
		logic [sumWidth-1:0] raw;         // Carry, hidden one, mantissa, GRS
		logic                zero;
	} sumT;

endpackage

`default_nettype wire
